/* source/cart_pkg.sv */
`default_nettype none

package cart_pkg;

    // bit 15 of a memory address splits PRG space (clear) from CHR space (set)
    localparam int mem_addr_bits = 16;
    localparam int chr_bank_bits = 2;

    typedef enum logic [0:0] {
        op_write  = 1'b0,
        op_config = 1'b1
    } host_op_t;

    typedef struct packed {
        logic                     loading;
        logic                     mirroring;
        logic [chr_bank_bits-1:0] chr_bank;
    } cart_cfg_t;

    typedef struct packed {
        host_op_t                 op;
        logic [6:0]               spare;
        logic [mem_addr_bits-1:0] addr;
        logic [7:0]               data;
    } host_write_t;

    typedef struct packed {
        host_op_t    op;
        logic [26:0] spare;
        cart_cfg_t   cfg;
    } host_config_t;

    // the op bit is the top bit in both views
    typedef union packed {
        host_write_t  wr;
        host_config_t conf;
    } host_cmd_u;

    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [mem_addr_bits-1:0] addr;
        logic [7:0]               wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* source/host_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module host_loader (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 host_valid,
    input  wire cart_pkg::host_cmd_u  host_word,
    input  wire logic                 grant,
    output cart_pkg::mem_req_t        req,
    output cart_pkg::cart_cfg_t       cfg
);

    logic                               write_pending;
    logic [cart_pkg::mem_addr_bits-1:0] write_addr;
    logic [7:0]                         write_data;
    logic                               accept;
    logic                               is_write;

    // words that arrive while a write waits for its grant are lost
    assign accept   = host_valid && !write_pending;
    assign is_write = host_word.wr.op == cart_pkg::op_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_pending <= 1'b0;
            cfg.loading   <= 1'b1;
            cfg.mirroring <= 1'b0;
            cfg.chr_bank  <= '0;
        end else begin
            if (grant) begin
                write_pending <= 1'b0;
            end
            if (accept) begin
                if (is_write) begin
                    write_pending <= 1'b1;
                end else begin
                    cfg <= host_word.conf.cfg;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_write) begin
            write_addr <= host_word.wr.addr;
            write_data <= host_word.wr.data;
        end
    end

    // a host write is done once granted, nothing comes back
    always_comb begin
        req.req   = write_pending;
        req.we    = 1'b1;
        req.addr  = write_addr;
        req.wdata = write_data;
    end

endmodule

`default_nettype wire

/* source/cart_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_ram (
    input  wire logic               clk,
    input  wire cart_pkg::mem_req_t req,
    output logic [7:0]              rd_data
);

    localparam int depth = 2 ** cart_pkg::mem_addr_bits;

    // stands in for the cartridge SDRAM, PRG in the low half and CHR above
    logic [7:0] mem [depth];

    always_ff @(posedge clk) begin
        if (req.req) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rd_data <= mem[req.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire cart_pkg::mem_req_t ppu_req,
    input  wire cart_pkg::mem_req_t cpu_req,
    input  wire cart_pkg::mem_req_t host_req,
    output logic                    ppu_grant,
    output logic                    cpu_grant,
    output logic                    host_grant,
    output logic                    ppu_rd_valid,
    output logic                    cpu_rd_valid,
    output logic [7:0]              rd_data
);

    cart_pkg::mem_req_t mem_req;

    // fixed priority, the PPU has the tightest timing on the console
    always_comb begin
        ppu_grant  = ppu_req.req;
        cpu_grant  = cpu_req.req && !ppu_req.req;
        host_grant = host_req.req && !ppu_req.req && !cpu_req.req;
    end

    always_comb begin
        if (ppu_grant) begin
            mem_req = ppu_req;
        end else if (cpu_grant) begin
            mem_req = cpu_req;
        end else if (host_grant) begin
            mem_req = host_req;
        end else begin
            mem_req = '0;
        end
    end

    // the memory answers one cycle after the grant, so the read channel is
    // remembered for exactly one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ppu_rd_valid <= 1'b0;
            cpu_rd_valid <= 1'b0;
        end else begin
            ppu_rd_valid <= ppu_grant && !ppu_req.we;
            cpu_rd_valid <= cpu_grant && !cpu_req.we;
        end
    end

    cart_ram i_cart_ram (
        .clk     (clk),
        .req     (mem_req),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* source/prg_port.sv */
`timescale 1ns/1ps
`default_nettype none

module prg_port (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                romsel_n,
    input  wire logic                cpu_rw,
    input  wire logic [14:0]         cpu_addr,
    input  wire cart_pkg::cart_cfg_t cfg,
    input  wire logic                grant,
    input  wire logic                rd_valid,
    input  wire logic [7:0]          rd_data,
    output cart_pkg::mem_req_t       req,
    output logic [7:0]               cpu_data,
    output logic                     cpu_dir
);

    logic                               cpu_read;
    logic                               active;
    logic                               need_fetch;
    logic [cart_pkg::mem_addr_bits-1:0] fetch_addr;
    logic [cart_pkg::mem_addr_bits-1:0] last_addr;

    assign cpu_read   = !romsel_n && cpu_rw && !cfg.loading;
    assign cpu_dir    = cpu_read;
    assign fetch_addr = {1'b0, cpu_addr};
    // a new byte is needed when a read starts or the address moves within it
    assign need_fetch = cpu_read && (!active || fetch_addr != last_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active    <= 1'b0;
            last_addr <= '0;
            req       <= '0;
            cpu_data  <= '0;
        end else begin
            active <= cpu_read;
            if (need_fetch) begin
                last_addr <= fetch_addr;
                req.req   <= 1'b1;
                req.addr  <= fetch_addr;
            end else if (grant) begin
                req.req <= 1'b0;
            end
            if (rd_valid) begin
                cpu_data <= rd_data;
            end
        end
    end

endmodule

`default_nettype wire

/* source/chr_port.sv */
`timescale 1ns/1ps
`default_nettype none

module chr_port (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                ppu_rd_n,
    input  wire logic [13:0]         ppu_addr,
    input  wire cart_pkg::cart_cfg_t cfg,
    input  wire logic                grant,
    input  wire logic                rd_valid,
    input  wire logic [7:0]          rd_data,
    output cart_pkg::mem_req_t       req,
    output logic [7:0]               ppu_data,
    output logic                     ppu_dir,
    output logic                     ciram_ce,
    output logic                     ciram_a10
);

    logic                               ppu_read;
    logic                               active;
    logic                               need_fetch;
    logic [cart_pkg::mem_addr_bits-1:0] fetch_addr;
    logic [cart_pkg::mem_addr_bits-1:0] last_addr;

    // the upper PPU half belongs to the console nametable RAM
    assign ciram_ce   = !ppu_addr[13];
    assign ciram_a10  = cfg.mirroring ? ppu_addr[10] : ppu_addr[11];
    assign ppu_read   = ciram_ce && !ppu_rd_n && !cfg.loading;
    assign ppu_dir    = ppu_read;
    assign fetch_addr = {1'b1, cfg.chr_bank, ppu_addr[12:0]};
    // the bank is part of the compared address, so a bank switch refetches too
    assign need_fetch = ppu_read && (!active || fetch_addr != last_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active    <= 1'b0;
            last_addr <= '0;
            req       <= '0;
            ppu_data  <= '0;
        end else begin
            active <= ppu_read;
            if (need_fetch) begin
                last_addr <= fetch_addr;
                req.req   <= 1'b1;
                req.addr  <= fetch_addr;
            end else if (grant) begin
                req.req <= 1'b0;
            end
            if (rd_valid) begin
                ppu_data <= rd_data;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_top (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        host_valid,
    input  wire logic [31:0] host_word,
    input  wire logic        romsel_n,
    input  wire logic        cpu_rw,
    input  wire logic [14:0] cpu_addr,
    input  wire logic        ppu_rd_n,
    input  wire logic [13:0] ppu_addr,
    output logic [7:0]       cpu_data,
    output logic             cpu_dir,
    output logic [7:0]       ppu_data,
    output logic             ppu_dir,
    output logic             ciram_ce,
    output logic             ciram_a10,
    output logic             loading
);

    cart_pkg::cart_cfg_t cfg;
    cart_pkg::host_cmd_u host_cmd;
    cart_pkg::mem_req_t  host_req;
    cart_pkg::mem_req_t  cpu_req;
    cart_pkg::mem_req_t  ppu_req;
    logic                host_grant;
    logic                cpu_grant;
    logic                ppu_grant;
    logic                cpu_rd_valid;
    logic                ppu_rd_valid;
    logic [7:0]          rd_data;

    assign host_cmd = host_word;
    assign loading  = cfg.loading;

    host_loader i_host_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_valid (host_valid),
        .host_word  (host_cmd),
        .grant      (host_grant),
        .req        (host_req),
        .cfg        (cfg)
    );

    mem_arbiter i_mem_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .ppu_req      (ppu_req),
        .cpu_req      (cpu_req),
        .host_req     (host_req),
        .ppu_grant    (ppu_grant),
        .cpu_grant    (cpu_grant),
        .host_grant   (host_grant),
        .ppu_rd_valid (ppu_rd_valid),
        .cpu_rd_valid (cpu_rd_valid),
        .rd_data      (rd_data)
    );

    prg_port i_prg_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .romsel_n (romsel_n),
        .cpu_rw   (cpu_rw),
        .cpu_addr (cpu_addr),
        .cfg      (cfg),
        .grant    (cpu_grant),
        .rd_valid (cpu_rd_valid),
        .rd_data  (rd_data),
        .req      (cpu_req),
        .cpu_data (cpu_data),
        .cpu_dir  (cpu_dir)
    );

    chr_port i_chr_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .ppu_rd_n  (ppu_rd_n),
        .ppu_addr  (ppu_addr),
        .cfg       (cfg),
        .grant     (ppu_grant),
        .rd_valid  (ppu_rd_valid),
        .rd_data   (rd_data),
        .req       (ppu_req),
        .ppu_data  (ppu_data),
        .ppu_dir   (ppu_dir),
        .ciram_ce  (ciram_ce),
        .ciram_a10 (ciram_a10)
    );

endmodule

`default_nettype wire

/* sim/tb_cart.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cart;

    localparam int timeout_cycles = 20;

    logic        clk;
    logic        arst_n;
    logic        host_valid;
    logic [31:0] host_word;
    logic        romsel_n;
    logic        cpu_rw;
    logic [14:0] cpu_addr;
    logic        ppu_rd_n;
    logic [13:0] ppu_addr;
    logic [7:0]  cpu_data;
    logic        cpu_dir;
    logic [7:0]  ppu_data;
    logic        ppu_dir;
    logic        ciram_ce;
    logic        ciram_a10;
    logic        loading;

    integer seed;
    integer error_count;
    integer start_errors;
    integer test_num;
    integer pass_count;
    integer fail_count;
    // expected loading flag as the config words last set it
    logic   loading_model;

    cart_top i_cart_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_valid (host_valid),
        .host_word  (host_word),
        .romsel_n   (romsel_n),
        .cpu_rw     (cpu_rw),
        .cpu_addr   (cpu_addr),
        .ppu_rd_n   (ppu_rd_n),
        .ppu_addr   (ppu_addr),
        .cpu_data   (cpu_data),
        .cpu_dir    (cpu_dir),
        .ppu_data   (ppu_data),
        .ppu_dir    (ppu_dir),
        .ciram_ce   (ciram_ce),
        .ciram_a10  (ciram_a10),
        .loading    (loading)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count = error_count + 1;
        end
    endtask

    task automatic report_test(input string what);
        test_num = test_num + 1;
        if (error_count == start_errors) begin
            pass_count = pass_count + 1;
            $display("test %0d ok: %s", test_num, what);
        end else begin
            fail_count = fail_count + 1;
            $display("test %0d failed: %s", test_num, what);
        end
    endtask

    task automatic idle_gap();
        integer gap;
        integer i;
        gap = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
        for (i = 0; i < gap; i++) begin
            @(negedge clk);
        end
    endtask

    // host words are spaced well apart so a pending write is never dropped
    task automatic send_host(input logic [31:0] word);
        integer i;
        host_valid = 1'b1;
        host_word  = word;
        @(negedge clk);
        host_valid = 1'b0;
        if (word[31]) begin
            loading_model = word[3];
        end
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic idle_checks(input logic check_cpu, input logic check_ppu);
        integer i;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("loading", loading, loading_model);
            if (check_cpu) begin
                check_value("cpu_dir", cpu_dir, 0);
            end
            if (check_ppu) begin
                check_value("ppu_dir", ppu_dir, 0);
            end
        end
    endtask

    task automatic run_reads(input logic do_cpu, input logic [14:0] c_addr,
                             input logic [7:0] c_exp, input logic do_ppu,
                             input logic [13:0] p_addr, input logic [7:0] p_exp,
                             input logic p_a10);
        integer waited;
        logic   ppu_fetch;
        logic   done;
        start_errors = error_count;
        ppu_fetch    = do_ppu && !p_addr[13] && !loading_model;
        romsel_n     = !do_cpu;
        cpu_addr     = c_addr;
        ppu_rd_n     = !do_ppu;
        ppu_addr     = p_addr;
        @(negedge clk);
        check_value("loading", loading, loading_model);
        if (do_ppu) begin
            check_value("ciram_ce", ciram_ce, !p_addr[13]);
            check_value("ciram_a10", ciram_a10, p_a10);
        end
        if (loading_model || (do_ppu && !ppu_fetch)) begin
            idle_checks(do_cpu, do_ppu);
        end else begin
            waited = 0;
            done   = (!do_cpu || cpu_data === c_exp) && (!ppu_fetch || ppu_data === p_exp);
            while (!done && waited < timeout_cycles) begin
                @(negedge clk);
                waited = waited + 1;
                done = (!do_cpu || cpu_data === c_exp) && (!ppu_fetch || ppu_data === p_exp);
            end
            if (!done) begin
                $display("read did not deliver the expected byte within %0d cycles",
                         timeout_cycles);
                error_count = error_count + 1;
            end
            if (do_cpu) begin
                check_value("cpu_data", cpu_data, c_exp);
                check_value("cpu_dir", cpu_dir, 1);
            end
            if (ppu_fetch) begin
                check_value("ppu_data", ppu_data, p_exp);
                check_value("ppu_dir", ppu_dir, 1);
            end
        end
        romsel_n = 1'b1;
        ppu_rd_n = 1'b1;
    endtask

    initial begin
        integer           fd;
        integer           code;
        integer           i;
        logic [63:0]      kind;
        logic [8*160-1:0] rest;
        logic [31:0]      word;
        logic [31:0]      c_addr;
        logic [31:0]      c_exp;
        logic [31:0]      p_addr;
        logic [31:0]      p_exp;
        logic [31:0]      p_a10;
        seed          = 32'h82e9_daa0;
        error_count   = 0;
        start_errors  = 0;
        test_num      = 0;
        pass_count    = 0;
        fail_count    = 0;
        loading_model = 1'b1;
        arst_n        = 1'b0;
        host_valid    = 1'b0;
        host_word     = '0;
        romsel_n      = 1'b1;
        cpu_rw        = 1'b1;
        cpu_addr      = '0;
        ppu_rd_n      = 1'b1;
        ppu_addr      = '0;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
        end
        arst_n = 1'b1;
        @(negedge clk);

        fd = $fopen("sim/cart_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file sim/cart_trace.txt");
            error_count = error_count + 1;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", kind);
                if (code == 1) begin
                    if (kind == "#") begin
                        code = $fgets(rest, fd);
                    end else if (kind == "H") begin
                        code = $fscanf(fd, "%h", word);
                        send_host(word);
                    end else if (kind == "C") begin
                        code = $fscanf(fd, "%h %h", c_addr, c_exp);
                        run_reads(1'b1, c_addr[14:0], c_exp[7:0], 1'b0, '0, '0, 1'b0);
                        report_test($sformatf("cpu read 0x%04h", c_addr[14:0]));
                    end else if (kind == "P") begin
                        code = $fscanf(fd, "%h %h %h", p_addr, p_exp, p_a10);
                        run_reads(1'b0, '0, '0, 1'b1, p_addr[13:0], p_exp[7:0], p_a10[0]);
                        report_test($sformatf("ppu read 0x%04h", p_addr[13:0]));
                    end else if (kind == "S") begin
                        code = $fscanf(fd, "%h %h %h %h %h", c_addr, c_exp, p_addr,
                                       p_exp, p_a10);
                        run_reads(1'b1, c_addr[14:0], c_exp[7:0], 1'b1, p_addr[13:0],
                                  p_exp[7:0], p_a10[0]);
                        report_test($sformatf("cpu read 0x%04h with ppu read 0x%04h",
                                              c_addr[14:0], p_addr[13:0]));
                    end else begin
                        $display("unknown record kind in the trace file");
                        error_count = error_count + 1;
                    end
                    idle_gap();
                end
            end
            $fclose(fd);
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cart_trace.txt */
# H host_word | C cpu_addr byte | P ppu_addr byte ciram_a10
# S cpu_addr cpu_byte ppu_addr ppu_byte ciram_a10 runs both reads at once
C 0010 00
P 0123 00 0
H 00001011
H 00123422
H 007fff33
H 008123a1
H 00a123b2
H 00880cc4
H 80000000
C 0010 11
C 1234 22
C 7fff 33
P 0123 a1 0
P 080c c4 1
H 80000005
P 0123 b2 0
P 2400 00 1
P 2800 00 0
H 80000000
P 2800 00 1
S 0010 11 0123 a1 0
S 1234 22 080c c4 1
S 7fff 33 0123 a1 0

/* project.f */
source/cart_pkg.sv
source/host_loader.sv
source/cart_ram.sv
source/mem_arbiter.sv
source/prg_port.sv
source/chr_port.sv
source/cart_top.sv
sim/tb_cart.sv
